/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       := tb_saturn_decoder
FILELIST  := project.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))
LOG       := sim.log

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Verification failed" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* dv/tb_saturn_decoder.sv */
// testbench for the nibble decoder top, drives random and directed instruction streams and checks records
`timescale 1ns/1ps

module tb_saturn_decoder import saturn_pkg::*; ();

    localparam int MAX_NIBS  = 24;                  // longest instruction is LC with 16 constants
    localparam int NUM_KINDS = 21;                  // 16 kept forms plus 5 invalid prefixes
    localparam int N_RANDOM  = 60;

    typedef struct packed {
        logic [15:0] prefix;                        // opcode nibbles, first one leftmost
        int          plen;
        int          len;                           // total nibbles incl. operands
    } instr_shape_t;

    logic           i_clk = 1'b0;
    logic           i_reset;
    logic           i_nib_valid;
    nibble_beat_t   i_nib;
    logic [3:0]     i_reg_p;
    logic           i_instr_ready;
    logic           o_nib_ready;
    logic           o_instr_valid;
    decoded_instr_t o_instr;

    logic [31:0]       stim_rng = 32'd39;
    logic [ADDR_W-1:0] cur_addr = '0;
    bit                bp_on = 1'b0;                // random stalls on the output
    int                errors = 0;
    int                gen_nibs = 0;
    int                instr_sent = 0;              // instructions fully accepted
    int                rx_count = 0;
    decoded_instr_t    exp_q[$];
    string             name_q[$];
    string             kind_names [NUM_KINDS] = '{
        "RTNSC", "RTNCC", "SETHEX", "SETDEC", "D0=(5)", "P=n", "LC", "GOTO", "CONFIG",
        "RESET", "C=P n", "CLRHST", "ST=0", "ST=1", "GOVLNG", "GOSBVL",
        "inv A", "inv 07", "inv 10", "inv 81", "inv 8E"
    };

    saturn_decoder_top saturn_decoder_top_inst (
        .i_clk         (i_clk),
        .i_reset       (i_reset),
        .i_nib_valid   (i_nib_valid),
        .i_nib         (i_nib),
        .i_reg_p       (i_reg_p),
        .i_instr_ready (i_instr_ready),
        .o_nib_ready   (o_nib_ready),
        .o_instr_valid (o_instr_valid),
        .o_instr       (o_instr)
    );

    always #2 i_clk = ~i_clk;                       // 4 ns period

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_rand();
        stim_rng = xorshift32(stim_rng);
        return stim_rng;
    endfunction

    function automatic instr_shape_t instr_shape(input int kind, input logic [3:0] lc_n);
        case (kind)
            0:  return '{prefix: 16'h0002, plen: 2, len: 2};
            1:  return '{prefix: 16'h0003, plen: 2, len: 2};
            2:  return '{prefix: 16'h0004, plen: 2, len: 2};
            3:  return '{prefix: 16'h0005, plen: 2, len: 2};
            4:  return '{prefix: 16'h001b, plen: 2, len: 7};
            5:  return '{prefix: 16'h0002, plen: 1, len: 2};
            6:  return '{prefix: 16'h0030 | 16'(lc_n), plen: 2, len: int'(lc_n) + 3};
            7:  return '{prefix: 16'h0006, plen: 1, len: 4};
            8:  return '{prefix: 16'h0805, plen: 3, len: 3};
            9:  return '{prefix: 16'h080a, plen: 3, len: 3};
            10: return '{prefix: 16'h080c, plen: 3, len: 4};
            11: return '{prefix: 16'h0082, plen: 2, len: 3};
            12: return '{prefix: 16'h0084, plen: 2, len: 3};
            13: return '{prefix: 16'h0085, plen: 2, len: 3};
            14: return '{prefix: 16'h008d, plen: 2, len: 7};
            15: return '{prefix: 16'h008f, plen: 2, len: 7};
            17: return '{prefix: 16'h0007, plen: 2, len: 2};
            18: return '{prefix: 16'h0010, plen: 2, len: 2};
            19: return '{prefix: 16'h0081, plen: 2, len: 2};
            20: return '{prefix: 16'h008e, plen: 2, len: 2};
            default: return '{prefix: 16'h000a, plen: 1, len: 1};  // lone A
        endcase
    endfunction

    // expected record from the opcode table, nibble k of the list sits at bits 4k+3:4k
    function automatic decoded_instr_t ref_decode(input logic [4*MAX_NIBS-1:0] nibs,
                                                  input logic [ADDR_W-1:0] pc,
                                                  input logic [3:0] p);
        decoded_instr_t r;
        logic [3:0]     n0;
        logic [3:0]     n1;
        logic [3:0]     n2;
        logic [3:0]     n3;
        int             count;
        int             op_start;
        r        = '0;
        n0       = nibs[3:0];
        n1       = nibs[7:4];
        n2       = nibs[11:8];
        n3       = nibs[15:12];
        count    = 0;
        op_start = 0;
        r.instr_pc   = pc;
        r.instr_type = INSTR_INVALID;               // unless a rule below matches
        case (n0)
            4'h0: if (n1 == 4'h2 || n1 == 4'h3) begin
                r.instr_type = INSTR_RTN;
                r.alu_op     = ALU_SET_CRY;
                r.imm        = {{(IMM_W-1){1'b0}}, n1 == 4'h2};
            end else if (n1 == 4'h4 || n1 == 4'h5) begin
                r.instr_type = INSTR_SET_MODE;
                r.imm        = {{(IMM_W-1){1'b0}}, n1 == 4'h5};
            end
            4'h1: if (n1 == 4'hb) begin
                r.instr_type = INSTR_LOAD;
                r.reg_dest   = REG_D0;
                r.ptr_end    = 4'h4;
                count        = 5;
                op_start     = 2;
            end
            4'h2: begin
                r.instr_type = INSTR_ALU;
                r.alu_op     = ALU_COPY;
                r.reg_dest   = REG_P;
                r.reg_src    = REG_IMM;
                count        = 1;
                op_start     = 1;
            end
            4'h3: begin
                r.instr_type = INSTR_LOAD;
                r.reg_dest   = REG_C;
                r.ptr_begin  = p;
                r.ptr_end    = p + n1;              // mod 16
                count        = int'(n1) + 1;
                op_start     = 2;
            end
            4'h6: begin
                r.instr_type = INSTR_JUMP;
                count        = 3;
                op_start     = 1;
            end
            4'h8: case (n1)
                4'h0: if (n2 == 4'h5) begin
                    r.instr_type = INSTR_CONFIG;
                end else if (n2 == 4'ha) begin
                    r.instr_type = INSTR_RESET;
                end else if (n2 == 4'hc) begin
                    r.instr_type = INSTR_ALU;
                    r.alu_op     = ALU_COPY;
                    r.reg_dest   = REG_C;
                    r.reg_src    = REG_P;
                    r.ptr_begin  = n3;
                    r.ptr_end    = n3;
                end
                4'h2: begin
                    r.instr_type = INSTR_ALU;
                    r.alu_op     = ALU_CLR_MASK;
                    r.reg_dest   = REG_HST;
                    r.reg_src    = REG_IMM;
                    count        = 1;
                    op_start     = 2;
                end
                4'h4, 4'h5: begin
                    r.instr_type = INSTR_ALU;
                    r.alu_op     = ALU_COPY;
                    r.reg_dest   = REG_ST;
                    r.reg_src    = REG_IMM;
                    r.imm        = {{(IMM_W-1){1'b0}}, n1 == 4'h5};
                    r.ptr_begin  = n2;
                    r.ptr_end    = n2;
                end
                4'hd, 4'hf: begin
                    r.instr_type = INSTR_JUMP;
                    r.push_pc    = (n1 == 4'hf);
                    count        = 5;
                    op_start     = 2;
                end
                default: ;
            endcase
            default: ;
        endcase
        for (int k = 0; k < count; k++) begin
            r.imm[4*k +: 4] = nibs[4*(op_start+k) +: 4];
        end
        r.operand_count = CNT_W'(count);
        return r;
    endfunction

    task automatic report_mismatch(input string test, input string field,
                                   input logic [63:0] want_val, input logic [63:0] got_val);
        $display("[ERROR] %s: %s expected %h, actual %h", test, field, want_val, got_val);
        errors++;
    endtask

    task automatic compare_record(input string name, input decoded_instr_t want,
                                  input decoded_instr_t got);
        if (got.instr_pc !== want.instr_pc)
            report_mismatch(name, "instr_pc", 64'(want.instr_pc), 64'(got.instr_pc));
        if (got.instr_type !== want.instr_type)
            report_mismatch(name, "instr_type", 64'(want.instr_type), 64'(got.instr_type));
        if (got.alu_op !== want.alu_op)
            report_mismatch(name, "alu_op", 64'(want.alu_op), 64'(got.alu_op));
        if (got.reg_dest !== want.reg_dest)
            report_mismatch(name, "reg_dest", 64'(want.reg_dest), 64'(got.reg_dest));
        if (got.reg_src !== want.reg_src)
            report_mismatch(name, "reg_src", 64'(want.reg_src), 64'(got.reg_src));
        if (got.ptr_begin !== want.ptr_begin)
            report_mismatch(name, "ptr_begin", 64'(want.ptr_begin), 64'(got.ptr_begin));
        if (got.ptr_end !== want.ptr_end)
            report_mismatch(name, "ptr_end", 64'(want.ptr_end), 64'(got.ptr_end));
        if (got.push_pc !== want.push_pc)
            report_mismatch(name, "push_pc", 64'(want.push_pc), 64'(got.push_pc));
        if (got.imm !== want.imm)
            report_mismatch(name, "imm", want.imm, got.imm);
        if (got.operand_count !== want.operand_count)
            report_mismatch(name, "operand_count", 64'(want.operand_count),
                            64'(got.operand_count));
    endtask

    // queues the expected record, then hands the nibbles over one handshake at a time
    task automatic send_instr(input string phase, input int kind, input logic [3:0] lc_n,
                              input logic [3:0] p, input bit gaps);
        instr_shape_t          shape;
        logic [4*MAX_NIBS-1:0] nibs;
        logic [31:0]           rnd;
        int                    gap;
        bit                    taken;
        shape = instr_shape(kind, lc_n);
        for (int k = 0; k < MAX_NIBS; k++) begin
            rnd             = next_rand();
            nibs[4*k +: 4] = rnd[7:4];              // operands stay random
        end
        for (int k = 0; k < shape.plen; k++) begin
            nibs[4*k +: 4] = shape.prefix[4*(shape.plen-1-k) +: 4];
        end
        gen_nibs += shape.len;
        exp_q.push_back(ref_decode(nibs, cur_addr, p));
        name_q.push_back($sformatf("%s %s #%0d", phase, kind_names[kind], instr_sent));
        for (int k = 0; k < shape.len; k++) begin
            gap = gaps ? int'(next_rand() % 3) : 0;
            repeat (gap) begin
                @(negedge i_clk);
                i_nib_valid = 1'b0;
            end
            @(negedge i_clk);
            if (k == 0) begin
                i_reg_p = p;                        // held for the whole instruction
            end
            i_nib_valid = 1'b1;
            i_nib.nib   = nibs[4*k +: 4];
            i_nib.addr  = cur_addr;
            taken       = 1'b0;
            while (!taken) begin
                #1;
                taken = o_nib_ready;                // settled well before the edge
                @(posedge i_clk);
                if (!taken) begin
                    @(negedge i_clk);
                end
            end
            cur_addr = cur_addr + ADDR_W'(1);
        end
        instr_sent++;
    endtask

    initial begin : ready_driver
        logic [31:0] ready_rng;
        ready_rng     = xorshift32(32'd39);
        i_instr_ready = 1'b0;
        forever begin
            @(negedge i_clk);
            ready_rng     = xorshift32(ready_rng);
            i_instr_ready = bp_on ? (ready_rng[2:0] > 3'd4) : 1'b1;  // mostly low under stress
        end
    end

    initial begin : monitor
        decoded_instr_t got;
        decoded_instr_t want;
        string          name;
        forever begin
            @(negedge i_clk);
            #1;
            if (!i_reset && o_instr_valid === 1'b1) begin
                if (rx_count >= instr_sent) begin
                    $display("error: output valid with no finished instruction outstanding");
                    errors++;
                end else if (i_instr_ready) begin
                    got  = o_instr;
                    want = exp_q.pop_front();
                    name = name_q.pop_front();
                    compare_record(name, want, got);
                    rx_count++;
                end
            end
        end
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles <= 40 * gen_nibs + 200) begin
            @(posedge i_clk);
            cycles++;
        end
        $display("timeout after %0d cycles, %0d of %0d records seen, %0d errors",
                 cycles, rx_count, instr_sent, errors);
        $display("Verification failed");
        $finish;
    end

    initial begin : stimulus
        logic [31:0] rnd;
        int          kind;
        i_reset     = 1'b1;
        i_nib_valid = 1'b0;
        i_nib       = '0;
        i_reg_p     = 4'h0;
        repeat (3) begin
            @(negedge i_clk);
            if (o_instr_valid !== 1'b0) begin
                $display("error: output valid is not low during reset");
                errors++;
            end
        end
        i_reset  = 1'b0;
        rnd      = next_rand();
        cur_addr = rnd[ADDR_W-1:0];                 // random start, contiguous after
        for (kind = 0; kind < 16; kind++) begin
            send_instr("directed", kind, 4'h2, 4'h5, 1'b0);
        end
        send_instr("lc_wrap", 6, 4'h5, 4'he, 1'b0);
        send_instr("lc_wrap", 6, 4'hf, 4'hf, 1'b0);  // all 16 constants
        send_instr("lc_wrap", 6, 4'h0, 4'hf, 1'b0);
        for (kind = 16; kind < NUM_KINDS; kind++) begin
            send_instr("invalid", kind, 4'h0, 4'h0, 1'b0);
            send_instr("recover", 5, 4'h0, 4'h0, 1'b0);
        end
        bp_on = 1'b1;
        for (int k = 0; k < N_RANDOM; k++) begin
            rnd  = next_rand();
            kind = int'(rnd % NUM_KINDS);
            send_instr("random", kind, rnd[11:8], rnd[15:12], 1'b1);
        end
        @(negedge i_clk);
        i_nib_valid = 1'b0;
        wait (rx_count == instr_sent);
        repeat (20) @(negedge i_clk);               // window for stray records
        $display("summary: %0d records checked, %0d errors", rx_count, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

/* project.f */
rtl/saturn_pkg.sv
rtl/saturn_prefix_decoder.sv
rtl/saturn_operand_collector.sv
rtl/saturn_instr_queue.sv
rtl/saturn_decoder_top.sv
dv/tb_saturn_decoder.sv

/* rtl/saturn_decoder_top.sv */
// decoder top, chains prefix decoder, operand collector and output queue for a nibble stream
`timescale 1ns/1ps

module saturn_decoder_top import saturn_pkg::*; (
    input  logic           i_clk,
    input  logic           i_reset,
    input  logic           i_nib_valid,
    input  nibble_beat_t   i_nib,
    input  logic [3:0]     i_reg_p,
    input  logic           i_instr_ready,
    output logic           o_nib_ready,
    output logic           o_instr_valid,
    output decoded_instr_t o_instr
);

    logic           beat_valid;
    collect_beat_t  beat;
    logic           beat_ready;
    logic           rec_valid;
    decoded_instr_t rec;
    logic           rec_ready;

    saturn_prefix_decoder saturn_prefix_decoder_inst (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_nib_valid  (i_nib_valid),
        .i_nib        (i_nib),
        .i_reg_p      (i_reg_p),
        .i_beat_ready (beat_ready),
        .o_nib_ready  (o_nib_ready),
        .o_beat_valid (beat_valid),
        .o_beat       (beat)
    );

    saturn_operand_collector saturn_operand_collector_inst (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_beat_valid (beat_valid),
        .i_beat       (beat),
        .i_rec_ready  (rec_ready),
        .o_beat_ready (beat_ready),
        .o_rec_valid  (rec_valid),
        .o_rec        (rec)
    );

    saturn_instr_queue saturn_instr_queue_inst (
        .i_clk         (i_clk),
        .i_reset       (i_reset),
        .i_rec_valid   (rec_valid),
        .i_rec         (rec),
        .i_instr_ready (i_instr_ready),
        .o_rec_ready   (rec_ready),
        .o_instr_valid (o_instr_valid),
        .o_instr       (o_instr)
    );

endmodule

/* rtl/saturn_instr_queue.sv */
// two-entry FIFO of finished records with a registered head driving the output handshake
`timescale 1ns/1ps

module saturn_instr_queue import saturn_pkg::*; (
    input  logic           i_clk,
    input  logic           i_reset,
    input  logic           i_rec_valid,
    input  decoded_instr_t i_rec,
    input  logic           i_instr_ready,
    output logic           o_rec_ready,
    output logic           o_instr_valid,
    output decoded_instr_t o_instr
);

    decoded_instr_t head_q;                         // oldest record, on the output
    decoded_instr_t tail_q;                         // second record when full
    logic [1:0]     count_q;
    logic           wr;
    logic           rd;

    assign o_rec_ready   = (count_q != QUEUE_DEPTH);
    assign o_instr_valid = (count_q != 2'd0);
    assign o_instr       = head_q;
    assign wr            = i_rec_valid & o_rec_ready;
    assign rd            = o_instr_valid & i_instr_ready;

    always_ff @(posedge i_clk) begin
        if (count_q == 2'd2) begin
            if (rd) begin
                head_q <= tail_q;                   // shift up
            end
        end else if (wr) begin
            if (count_q == 2'd0 || rd) begin
                head_q <= i_rec;                    // goes straight to the head
            end else begin
                tail_q <= i_rec;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            count_q <= 2'd0;
        end else if (wr && !rd) begin
            count_q <= count_q + 2'd1;
        end else if (rd && !wr) begin
            count_q <= count_q - 2'd1;
        end
    end

    // occupancy never grows past the two entries
    a_no_overflow: assert property (@(posedge i_clk) disable iff (i_reset)
        count_q <= QUEUE_DEPTH);

endmodule

/* rtl/saturn_operand_collector.sv */
// gathers a header beat and its operand nibbles into one decoded record held for the queue
`timescale 1ns/1ps

module saturn_operand_collector import saturn_pkg::*; (
    input  logic           i_clk,
    input  logic           i_reset,
    input  logic           i_beat_valid,
    input  collect_beat_t  i_beat,
    input  logic           i_rec_ready,
    output logic           o_beat_ready,
    output logic           o_rec_valid,
    output decoded_instr_t o_rec
);

    decoded_instr_t   rec_q;                        // record under construction
    logic [CNT_W-1:0] idx_q;                        // next imm nibble slot
    logic             full_q;                       // record complete, waiting
    logic             beat_fire;
    logic             rec_fire;

    assign o_beat_ready = ~full_q;                  // stall while a record is held
    assign o_rec_valid  = full_q;
    assign o_rec        = rec_q;
    assign beat_fire    = i_beat_valid & o_beat_ready;
    assign rec_fire     = full_q & i_rec_ready;

    always_ff @(posedge i_clk) begin
        if (beat_fire) begin
            if (!i_beat.is_operand) begin
                rec_q <= i_beat.header;             // keeps the imm seed
            end else begin
                rec_q.imm[idx_q[CNT_W-2:0] * NIB_W +: NIB_W] <= i_beat.operand;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            full_q <= 1'b0;
            idx_q  <= '0;
        end else begin
            if (beat_fire) begin
                if (!i_beat.is_operand) begin
                    idx_q <= '0;
                end else begin
                    idx_q <= idx_q + CNT_W'(1);
                end
                if (i_beat.last) begin
                    full_q <= 1'b1;
                end
            end else if (rec_fire) begin
                full_q <= 1'b0;                     // queue took it
            end
        end
    end

    // decoder never sends more operands than imm can hold
    a_idx_in_range: assert property (@(posedge i_clk) disable iff (i_reset)
        (beat_fire && i_beat.is_operand) |-> (idx_q < IMM_NIBS));

endmodule

/* rtl/saturn_pkg.sv */
// shared widths, enums and record structs for the nibble decoder, imported by all RTL and the testbench
package saturn_pkg;

    localparam int NIB_W       = 4;                 // one saturn nibble
    localparam int ADDR_W      = 20;                // nibble address space
    localparam int IMM_NIBS    = 16;                // LC can carry up to 16 constants
    localparam int IMM_W       = IMM_NIBS * NIB_W;  // 64 bit immediate
    localparam int CNT_W       = 5;                 // holds 0..16
    localparam int QUEUE_DEPTH = 2;                 // finished records waiting at the output

    // one nibble fetched from memory
    typedef struct packed {
        logic [NIB_W-1:0]  nib;
        logic [ADDR_W-1:0] addr;                    // where the nibble came from
    } nibble_beat_t;

    typedef enum logic [3:0] {
        INSTR_NONE     = 4'd0,
        INSTR_RTN      = 4'd1,
        INSTR_SET_MODE = 4'd2,
        INSTR_ALU      = 4'd3,
        INSTR_LOAD     = 4'd4,
        INSTR_JUMP     = 4'd5,
        INSTR_CONFIG   = 4'd6,
        INSTR_RESET    = 4'd7,
        INSTR_INVALID  = 4'd8                       // unknown opcode nibble
    } instr_type_e;

    typedef enum logic [1:0] {
        ALU_NOP      = 2'd0,
        ALU_COPY     = 2'd1,
        ALU_SET_CRY  = 2'd2,                        // carry from imm bit 0
        ALU_CLR_MASK = 2'd3                         // clear bits given by imm
    } alu_op_e;

    typedef enum logic [2:0] {
        REG_NONE = 3'd0,
        REG_C    = 3'd1,
        REG_D0   = 3'd2,
        REG_P    = 3'd3,
        REG_ST   = 3'd4,
        REG_HST  = 3'd5,
        REG_IMM  = 3'd6                             // operand comes from imm
    } alu_reg_e;

    // one complete decoded instruction
    typedef struct packed {
        logic [ADDR_W-1:0] instr_pc;                // address of first nibble
        instr_type_e       instr_type;
        alu_op_e           alu_op;
        alu_reg_e          reg_dest;
        alu_reg_e          reg_src;
        logic [3:0]        ptr_begin;
        logic [3:0]        ptr_end;
        logic              push_pc;                 // GOSBVL pushes return address
        logic [IMM_W-1:0]  imm;                     // operand k in bits 4k+3:4k
        logic [CNT_W-1:0]  operand_count;
    } decoded_instr_t;

    // beat from the prefix decoder to the operand collector
    typedef struct packed {
        decoded_instr_t   header;                   // imm holds the seed value
        logic [NIB_W-1:0] operand;
        logic             is_operand;               // 0 means header beat
        logic             last;                     // closes the instruction
    } collect_beat_t;

    // the IDLE state expects the first opcode nibble
    typedef enum logic [3:0] {
        DEC_IDLE     = 4'd0,
        DEC_BLK_0X   = 4'd1,
        DEC_BLK_1X   = 4'd2,
        DEC_BLK_3X   = 4'd3,
        DEC_BLK_8X   = 4'd4,
        DEC_BLK_80X  = 4'd5,
        DEC_BLK_80CX = 4'd6,
        DEC_BLK_84X  = 4'd7,
        DEC_OPERANDS = 4'd8                         // counting operand nibbles
    } dec_state_e;

endpackage

/* rtl/saturn_prefix_decoder.sv */
// opcode prefix FSM that classifies each instruction and feeds header and operand beats onward
`timescale 1ns/1ps

module saturn_prefix_decoder import saturn_pkg::*; (
    input  logic          i_clk,
    input  logic          i_reset,
    input  logic          i_nib_valid,
    input  nibble_beat_t  i_nib,
    input  logic [3:0]    i_reg_p,
    input  logic          i_beat_ready,
    output logic          o_nib_ready,
    output logic          o_beat_valid,
    output collect_beat_t o_beat
);

    dec_state_e       state_q, state_d;
    decoded_instr_t   hdr_q, hdr_d;                 // header built so far
    logic [CNT_W-1:0] remain_q, remain_d;           // operands still to come
    logic             hdr_done;                     // this nibble completes the header
    logic             bad;                          // unknown opcode nibble
    logic             is_oper;
    logic             last;
    logic             emit;
    logic             nib_fire;

    always_comb begin
        hdr_d    = hdr_q;
        state_d  = state_q;
        remain_d = remain_q;
        hdr_done = 1'b0;
        bad      = 1'b0;
        is_oper  = 1'b0;
        last     = 1'b0;

        if (state_q == DEC_IDLE) begin
            hdr_d          = '0;                    // fresh record
            hdr_d.instr_pc = i_nib.addr;
        end

        case (state_q)
            DEC_IDLE: begin
                case (i_nib.nib)
                    4'h0: state_d = DEC_BLK_0X;
                    4'h1: state_d = DEC_BLK_1X;
                    4'h2: begin                     // P=n with n as the operand
                        hdr_d.instr_type    = INSTR_ALU;
                        hdr_d.alu_op        = ALU_COPY;
                        hdr_d.reg_dest      = REG_P;
                        hdr_d.reg_src       = REG_IMM;
                        hdr_d.operand_count = CNT_W'(1);
                        hdr_done            = 1'b1;
                    end
                    4'h3: state_d = DEC_BLK_3X;
                    4'h6: begin                     // GOTO
                        hdr_d.instr_type    = INSTR_JUMP;
                        hdr_d.operand_count = CNT_W'(3);
                        hdr_done            = 1'b1;
                    end
                    4'h8: state_d = DEC_BLK_8X;
                    default: bad = 1'b1;
                endcase
            end
            DEC_BLK_0X: begin
                case (i_nib.nib)
                    4'h2, 4'h3: begin               // RTNSC / RTNCC
                        hdr_d.instr_type = INSTR_RTN;
                        hdr_d.alu_op     = ALU_SET_CRY;
                        hdr_d.imm        = {{(IMM_W-1){1'b0}}, ~i_nib.nib[0]};
                        hdr_done         = 1'b1;
                    end
                    4'h4, 4'h5: begin               // SETHEX / SETDEC
                        hdr_d.instr_type = INSTR_SET_MODE;
                        hdr_d.imm        = {{(IMM_W-1){1'b0}}, i_nib.nib[0]};
                        hdr_done         = 1'b1;
                    end
                    default: bad = 1'b1;
                endcase
            end
            DEC_BLK_1X: begin
                if (i_nib.nib == 4'hB) begin        // D0=(5)
                    hdr_d.instr_type    = INSTR_LOAD;
                    hdr_d.reg_dest      = REG_D0;
                    hdr_d.ptr_begin     = 4'h0;
                    hdr_d.ptr_end       = 4'h4;
                    hdr_d.operand_count = CNT_W'(5);
                    hdr_done            = 1'b1;
                end else begin
                    bad = 1'b1;
                end
            end
            DEC_BLK_3X: begin                       // LC loads n+1 constants from P
                hdr_d.instr_type    = INSTR_LOAD;
                hdr_d.reg_dest      = REG_C;
                hdr_d.ptr_begin     = i_reg_p;
                hdr_d.ptr_end       = i_reg_p + i_nib.nib;  // wraps mod 16
                hdr_d.operand_count = {1'b0, i_nib.nib} + CNT_W'(1);
                hdr_done            = 1'b1;
            end
            DEC_BLK_8X: begin
                case (i_nib.nib)
                    4'h0: state_d = DEC_BLK_80X;
                    4'h2: begin                     // clear HST bits
                        hdr_d.instr_type    = INSTR_ALU;
                        hdr_d.alu_op        = ALU_CLR_MASK;
                        hdr_d.reg_dest      = REG_HST;
                        hdr_d.reg_src       = REG_IMM;
                        hdr_d.operand_count = CNT_W'(1);
                        hdr_done            = 1'b1;
                    end
                    4'h4, 4'h5: begin               // ST=0 / ST=1 with the bit in the next nibble
                        hdr_d.instr_type = INSTR_ALU;
                        hdr_d.alu_op     = ALU_COPY;
                        hdr_d.reg_dest   = REG_ST;
                        hdr_d.reg_src    = REG_IMM;
                        hdr_d.imm        = {{(IMM_W-1){1'b0}}, i_nib.nib[0]};
                        state_d          = DEC_BLK_84X;
                    end
                    4'hD, 4'hF: begin               // GOVLNG / GOSBVL
                        hdr_d.instr_type    = INSTR_JUMP;
                        hdr_d.push_pc       = i_nib.nib[1];
                        hdr_d.operand_count = CNT_W'(5);
                        hdr_done            = 1'b1;
                    end
                    default: bad = 1'b1;
                endcase
            end
            DEC_BLK_80X: begin
                case (i_nib.nib)
                    4'h5: begin
                        hdr_d.instr_type = INSTR_CONFIG;
                        hdr_done         = 1'b1;
                    end
                    4'hA: begin
                        hdr_d.instr_type = INSTR_RESET;
                        hdr_done         = 1'b1;
                    end
                    4'hC: state_d = DEC_BLK_80CX;
                    default: bad = 1'b1;
                endcase
            end
            DEC_BLK_80CX: begin                     // C=P n
                hdr_d.instr_type = INSTR_ALU;
                hdr_d.alu_op     = ALU_COPY;
                hdr_d.reg_dest   = REG_C;
                hdr_d.reg_src    = REG_P;
                hdr_d.ptr_begin  = i_nib.nib;
                hdr_d.ptr_end    = i_nib.nib;
                hdr_done         = 1'b1;
            end
            DEC_BLK_84X: begin
                hdr_d.ptr_begin = i_nib.nib;
                hdr_d.ptr_end   = i_nib.nib;
                hdr_done        = 1'b1;
            end
            DEC_OPERANDS: begin
                is_oper  = 1'b1;
                last     = (remain_q == CNT_W'(1));
                remain_d = remain_q - CNT_W'(1);
                if (last) begin
                    state_d = DEC_IDLE;
                end
            end
            default: state_d = DEC_IDLE;
        endcase

        if (bad) begin
            hdr_d.instr_type = INSTR_INVALID;
            hdr_done         = 1'b1;
        end

        if (hdr_done) begin
            if (hdr_d.operand_count == '0) begin
                last    = 1'b1;
                state_d = DEC_IDLE;
            end else begin
                state_d  = DEC_OPERANDS;
                remain_d = hdr_d.operand_count;
            end
        end
    end

    assign emit         = hdr_done | is_oper;
    assign o_nib_ready  = emit ? i_beat_ready : 1'b1;   // prefix nibbles never stall
    assign o_beat_valid = i_nib_valid & emit;
    assign nib_fire     = i_nib_valid & o_nib_ready;

    assign o_beat.header     = hdr_d;
    assign o_beat.operand    = i_nib.nib;
    assign o_beat.is_operand = is_oper;
    assign o_beat.last       = last;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state_q  <= DEC_IDLE;
            remain_q <= '0;
        end else if (nib_fire) begin
            state_q  <= state_d;
            remain_q <= remain_d;
        end
    end

    always_ff @(posedge i_clk) begin
        if (nib_fire) begin
            hdr_q <= hdr_d;
        end
    end

    // operand phase always has work to do
    a_operands_nonzero: assert property (@(posedge i_clk) disable iff (i_reset)
        (state_q == DEC_OPERANDS) |-> (remain_q != '0));

    // stalled beat must not change under the collector
    a_beat_stable: assert property (@(posedge i_clk) disable iff (i_reset)
        (o_beat_valid && !i_beat_ready) |=> (o_beat_valid && $stable(o_beat)));

endmodule
